// File: verilog/reuleaux_pkg.sv
`default_nettype none

package reuleaux_pkg;

    // screen coordinates as seen by the frame-buffer writer
    typedef logic [7:0] coord_x_t;
    typedef logic [6:0] coord_y_t;

    // signed coordinates for vertices that may sit off screen
    typedef logic signed [8:0] scoord_x_t;
    typedef logic signed [7:0] scoord_y_t;

    typedef logic [2:0] colour_t;

    typedef struct packed {
        scoord_x_t x;
        scoord_y_t y;
    } vertex_t;

    typedef struct packed {
        vertex_t top;
        vertex_t left;
        vertex_t right;
    } vertex_set_t;

    typedef struct packed {
        coord_x_t x;
        coord_y_t y;
        colour_t  colour;
        logic     plot;   // one-cycle write strobe
    } pixel_t;

    // arcs in drawing order
    typedef enum logic [1:0] {arc_right, arc_left, arc_top} arc_sel_e;

    typedef enum logic [2:0] {
        seq_idle, seq_calc, seq_load, seq_trace, seq_finished, seq_hold
    } seq_state_e;

    typedef enum logic [1:0] {
        eng_idle, eng_first_oct, eng_second_oct, eng_done
    } eng_state_e;

    // sqrt(3)/6 and sqrt(3)/3 as pure fractions
    localparam int frac_bits = 12;
    localparam logic [frac_bits-1:0] sqrt3_div6 = 12'h49E;  // 0.28867
    localparam logic [frac_bits-1:0] sqrt3_div3 = 12'h93D;  // 0.57735

endpackage

`default_nettype wire

// File: verilog/vertex_calc.sv
`timescale 1ns/1ps
`default_nettype none

module vertex_calc (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire logic                      calc,
    input  wire reuleaux_pkg::coord_x_t    centre_x,
    input  wire reuleaux_pkg::coord_y_t    centre_y,
    input  wire logic [7:0]                diameter,
    output reuleaux_pkg::vertex_set_t      vertices
);

    localparam int fb = reuleaux_pkg::frac_bits;

    logic [fb+7:0]                prod6;     // d * sqrt(3)/6 with fb fraction bits
    logic [fb+7:0]                prod3;     // d * sqrt(3)/3
    logic [7:0]                   ofs6;
    logic [7:0]                   ofs3;
    logic [6:0]                   half_d;
    reuleaux_pkg::scoord_x_t      cx;
    reuleaux_pkg::scoord_y_t      cy;
    reuleaux_pkg::vertex_set_t    vert_next;

    assign prod6 = diameter * reuleaux_pkg::sqrt3_div6;
    assign prod3 = diameter * reuleaux_pkg::sqrt3_div3;

    // round up when the first fraction bit is set
    assign ofs6 = prod6[fb+7:fb] + prod6[fb-1];
    assign ofs3 = prod3[fb+7:fb] + prod3[fb-1];

    assign half_d = diameter[7:1];
    assign cx     = {1'b0, centre_x};      // zero extend into the signed range
    assign cy     = {1'b0, centre_y};

    always_comb begin
        vert_next.top.x   = cx;
        vert_next.top.y   = cy - ofs3;
        vert_next.left.x  = cx - {2'b00, half_d};
        vert_next.left.y  = cy + ofs6;
        vert_next.right.x = cx + {2'b00, half_d};
        vert_next.right.y = cy + ofs6;   // lower vertices share a row
    end

    // held until the next calc
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vertices <= '0;
        end else if (calc) begin
            vertices <= vert_next;
        end
    end

endmodule

`default_nettype wire

// File: verilog/arc_engine.sv
`timescale 1ns/1ps
`default_nettype none

module arc_engine #(
    parameter int screen_w = 160,
    parameter int screen_h = 120
) (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire logic                        arc_go,
    input  wire reuleaux_pkg::arc_sel_e      arc_sel,
    input  wire reuleaux_pkg::vertex_set_t   vertices,
    input  wire logic [7:0]                  diameter,
    input  wire reuleaux_pkg::colour_t       colour,
    output reuleaux_pkg::pixel_t             pixel,
    output logic                             arc_done
);

    reuleaux_pkg::eng_state_e   state;

    // midpoint state
    logic signed [9:0]          ofs_x;
    logic signed [9:0]          ofs_y;
    logic signed [11:0]         crit;
    logic signed [9:0]          x_next;
    logic signed [9:0]          y_next;
    logic signed [11:0]         crit_next;

    reuleaux_pkg::vertex_t      ctr;     // arc centre
    reuleaux_pkg::vertex_t      bnd;     // wedge end vertex for this octant
    reuleaux_pkg::scoord_x_t    cx;
    reuleaux_pkg::scoord_y_t    cy;
    reuleaux_pkg::scoord_x_t    bx;
    reuleaux_pkg::scoord_y_t    by;
    logic signed [10:0]         px;
    logic signed [10:0]         py;
    logic                       second;
    logic                       in_wedge;
    logic                       on_screen;
    logic                       emit;

    reuleaux_pkg::coord_x_t     pix_x;
    reuleaux_pkg::coord_y_t     pix_y;
    reuleaux_pkg::colour_t      pix_colour;
    logic                       plot_q;

    assign y_next    = ofs_y + 10'sd1;
    assign x_next    = (crit <= 0) ? ofs_x : ofs_x - 10'sd1;
    assign crit_next = (crit <= 0) ? crit + 12'sd2 * y_next + 12'sd1
                                   : crit + 12'sd2 * (y_next - x_next) + 12'sd1;

    assign second = (state == reuleaux_pkg::eng_second_oct);

    // centre and wedge bound per arc and octant
    always_comb begin
        case (arc_sel)
            reuleaux_pkg::arc_right: begin
                ctr = vertices.right;
                bnd = second ? vertices.top : vertices.left;
            end
            reuleaux_pkg::arc_left: begin
                ctr = vertices.left;
                bnd = second ? vertices.right : vertices.top;
            end
            default: begin
                ctr = vertices.top;
                bnd = second ? vertices.left : vertices.right;
            end
        endcase
    end

    assign cx = ctr.x;
    assign cy = ctr.y;
    assign bx = bnd.x;
    assign by = bnd.y;

    // candidate point and wedge test
    always_comb begin
        case (arc_sel)
            reuleaux_pkg::arc_right: begin
                if (!second) begin
                    px       = cx - ofs_x;
                    py       = cy - ofs_y;
                    in_wedge = (px >= bx) && (py <= by);
                end else begin
                    px       = cx - ofs_y;
                    py       = cy - ofs_x;
                    in_wedge = (px <= bx) && (py >= by);
                end
            end
            reuleaux_pkg::arc_left: begin
                if (!second) begin
                    px       = cx + ofs_y;
                    py       = cy - ofs_x;
                    in_wedge = (px >= bx) && (py >= by);
                end else begin
                    px       = cx + ofs_x;
                    py       = cy - ofs_y;
                    in_wedge = (px <= bx) && (py <= by);
                end
            end
            default: begin
                if (!second) begin
                    px       = cx + ofs_y;
                    py       = cy + ofs_x;
                    in_wedge = (px <= bx) && (py >= by);
                end else begin
                    px       = cx - ofs_y;
                    py       = cy + ofs_x;
                    in_wedge = (px >= bx) && (py >= by);
                end
            end
        endcase
    end

    assign on_screen = (px >= 0) && (px < screen_w) && (py >= 0) && (py < screen_h);

    // a candidate exists in every second-octant cycle and while x >= y
    assign emit = second || ((state == reuleaux_pkg::eng_first_oct) && (ofs_x >= ofs_y));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= reuleaux_pkg::eng_idle;
            plot_q <= 1'b0;
        end else begin
            plot_q <= emit && in_wedge && on_screen;
            case (state)
                reuleaux_pkg::eng_idle:
                    if (arc_go) state <= reuleaux_pkg::eng_first_oct;
                reuleaux_pkg::eng_first_oct:
                    state <= (ofs_x >= ofs_y) ? reuleaux_pkg::eng_second_oct
                                              : reuleaux_pkg::eng_done;
                reuleaux_pkg::eng_second_oct:
                    state <= reuleaux_pkg::eng_first_oct;
                default:
                    state <= reuleaux_pkg::eng_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == reuleaux_pkg::eng_idle) && arc_go) begin
            ofs_x <= {2'b00, diameter};
            ofs_y <= '0;
            crit  <= 12'sd1 - $signed({4'b0000, diameter});
        end else if (second) begin      // step after the second point
            ofs_x <= x_next;
            ofs_y <= y_next;
            crit  <= crit_next;
        end
        pix_x      <= px[7:0];
        pix_y      <= py[6:0];
        pix_colour <= colour;
    end

    assign pixel    = '{x: pix_x, y: pix_y, colour: pix_colour, plot: plot_q};
    assign arc_done = (state == reuleaux_pkg::eng_done);

endmodule

`default_nettype wire

// File: verilog/arc_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module arc_sequencer (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                start,
    input  wire logic                arc_done,
    output logic                     calc,
    output logic                     arc_go,
    output reuleaux_pkg::arc_sel_e   arc_sel,
    output logic                     done
);

    reuleaux_pkg::seq_state_e   state;
    reuleaux_pkg::seq_state_e   state_next;
    logic                       last_arc;

    assign last_arc = (arc_sel == reuleaux_pkg::arc_top);

    always_comb begin
        state_next = state;
        case (state)
            reuleaux_pkg::seq_idle:
                if (start) state_next = reuleaux_pkg::seq_calc;
            reuleaux_pkg::seq_calc:
                state_next = reuleaux_pkg::seq_load;   // vertices valid next cycle
            reuleaux_pkg::seq_load:
                state_next = reuleaux_pkg::seq_trace;
            reuleaux_pkg::seq_trace: begin
                if (arc_done) begin
                    state_next = last_arc ? reuleaux_pkg::seq_finished
                                          : reuleaux_pkg::seq_load;
                end
            end
            reuleaux_pkg::seq_finished:
                state_next = reuleaux_pkg::seq_hold;
            reuleaux_pkg::seq_hold:
                if (!start) state_next = reuleaux_pkg::seq_idle;  // wait for start to drop
            default:
                state_next = reuleaux_pkg::seq_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= reuleaux_pkg::seq_idle;
            arc_sel <= reuleaux_pkg::arc_right;
        end else begin
            state <= state_next;
            if (state == reuleaux_pkg::seq_calc) begin
                arc_sel <= reuleaux_pkg::arc_right;
            end else if ((state == reuleaux_pkg::seq_trace) && arc_done && !last_arc) begin
                // right, then left, then top
                arc_sel <= (arc_sel == reuleaux_pkg::arc_right) ? reuleaux_pkg::arc_left
                                                                : reuleaux_pkg::arc_top;
            end
        end
    end

    assign calc   = (state == reuleaux_pkg::seq_calc);
    assign arc_go = (state == reuleaux_pkg::seq_load);
    assign done   = (state == reuleaux_pkg::seq_hold);

endmodule

`default_nettype wire

// File: verilog/reuleaux_top.sv
`timescale 1ns/1ps
`default_nettype none

module reuleaux_top #(
    parameter int screen_w = 160,
    parameter int screen_h = 120
) (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire logic                      start,
    input  wire reuleaux_pkg::coord_x_t    centre_x,
    input  wire reuleaux_pkg::coord_y_t    centre_y,
    input  wire logic [7:0]                diameter,
    input  wire reuleaux_pkg::colour_t     colour,
    output reuleaux_pkg::pixel_t           pixel,
    output logic                           done
);

    logic                          calc;
    logic                          arc_go;
    logic                          arc_done;
    reuleaux_pkg::arc_sel_e        arc_sel;
    reuleaux_pkg::vertex_set_t     vertices;

    vertex_calc vertex_calc_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .calc     (calc),
        .centre_x (centre_x),
        .centre_y (centre_y),
        .diameter (diameter),
        .vertices (vertices)
    );

    arc_sequencer arc_sequencer_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .arc_done (arc_done),
        .calc     (calc),
        .arc_go   (arc_go),
        .arc_sel  (arc_sel),
        .done     (done)
    );

    arc_engine #(
        .screen_w (screen_w),
        .screen_h (screen_h)
    ) arc_engine_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .arc_go   (arc_go),
        .arc_sel  (arc_sel),
        .vertices (vertices),
        .diameter (diameter),
        .colour   (colour),
        .pixel    (pixel),
        .arc_done (arc_done)
    );

endmodule

`default_nettype wire

// File: testbench/reuleaux_checker.sv
`timescale 1ns/1ps
`default_nettype none

module reuleaux_checker #(
    parameter int screen_w = 160,
    parameter int screen_h = 120
) (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire logic                      start,
    input  wire reuleaux_pkg::coord_x_t    centre_x,
    input  wire reuleaux_pkg::coord_y_t    centre_y,
    input  wire logic [7:0]                diameter,
    input  wire reuleaux_pkg::colour_t     colour,
    input  wire logic [8*8-1:0]            test_name,
    input  wire logic [15:0]               exp_count,
    input  wire reuleaux_pkg::pixel_t      pixel,
    input  wire logic                      done,
    output int                             errors,
    output int                             tests
);

    int  exp_x[$];
    int  exp_y[$];
    int  got_x[$];
    int  got_y[$];
    int  test_errs;
    bit  busy;       // between start rising and done rising
    bit  holding;    // done seen high, waiting for it to fall
    bit  start_q;

    task automatic note_error();
        errors++;
        test_errs++;
    endtask

    // expected plotted pixels in drawing order
    task automatic build_model(input int cx, input int cy, input int d);
        int r3, r6, h;
        int tx, ty, lx, ly, rx, ry;
        int ax, ay, x, y, crit, px, py, arc, oct;
        bit keep;
        r3 = (d * 'h93D + 2048) / 4096;   // round up on the first fraction bit
        r6 = (d * 'h49E + 2048) / 4096;
        h  = d / 2;
        tx = cx;
        ty = cy - r3;
        lx = cx - h;
        ly = cy + r6;
        rx = cx + h;
        ry = cy + r6;
        exp_x.delete();
        exp_y.delete();
        for (arc = 0; arc < 3; arc++) begin
            ax   = (arc == 0) ? rx : (arc == 1) ? lx : tx;
            ay   = (arc == 0) ? ry : (arc == 1) ? ly : ty;
            x    = d;
            y    = 0;
            crit = 1 - d;
            while (x >= y) begin
                for (oct = 0; oct < 2; oct++) begin
                    case (arc)
                        0: begin
                            px   = oct ? ax - y : ax - x;
                            py   = oct ? ay - x : ay - y;
                            keep = oct ? (px <= tx && py >= ty) : (px >= lx && py <= ly);
                        end
                        1: begin
                            px   = oct ? ax + x : ax + y;
                            py   = oct ? ay - y : ay - x;
                            keep = oct ? (px <= rx && py <= ry) : (px >= tx && py >= ty);
                        end
                        default: begin   // bottom arc around the top vertex
                            px   = oct ? ax - y : ax + y;
                            py   = ay + x;
                            keep = oct ? (px >= lx && py >= ly) : (px <= rx && py >= ry);
                        end
                    endcase
                    if (keep && px >= 0 && px < screen_w && py >= 0 && py < screen_h) begin
                        exp_x.push_back(px);
                        exp_y.push_back(py);
                    end
                end
                y++;
                if (crit <= 0) begin
                    crit += 2 * y + 1;
                end else begin
                    x--;
                    crit += 2 * (y - x) + 1;
                end
            end
        end
    endtask

    task automatic finish_test();
        int  k;
        bit  bad;
        if (exp_x.size() != exp_count) begin
            $display("CHECK FAILED %0s: model pixel count expected %0d actual %0d",
                     test_name, exp_count, exp_x.size());
            note_error();
        end
        if (got_x.size() != exp_x.size()) begin
            $display("CHECK FAILED %0s: pixel count expected %0d actual %0d",
                     test_name, exp_x.size(), got_x.size());
            note_error();
        end
        bad = 1'b0;
        for (k = 0; k < exp_x.size() && k < got_x.size() && !bad; k++) begin
            if (got_x[k] != exp_x[k] || got_y[k] != exp_y[k]) begin
                $display("CHECK FAILED %0s: pixel %0d expected (%0d,%0d) actual (%0d,%0d)",
                         test_name, k, exp_x[k], exp_y[k], got_x[k], got_y[k]);
                note_error();
                bad = 1'b1;     // later pixels would only repeat the shift
            end
        end
        tests++;
        $display("test %0s: %0d pixels plotted, %0s", test_name, got_x.size(),
                 (test_errs == 0) ? "ok" : "mismatch");
    endtask

    // sampled mid-cycle, away from the rising edge
    always @(negedge clk) begin
        if (!rst_n) begin
            errors  = 0;
            tests   = 0;
            busy    = 1'b0;
            holding = 1'b0;
        end else begin
            if (start && !start_q && !busy) begin
                build_model(centre_x, centre_y, diameter);
                got_x.delete();
                got_y.delete();
                test_errs = 0;
                busy      = 1'b1;
            end
            if (pixel.plot) begin
                if (!busy) begin
                    $display("error in %0s: pixel strobe while no drawing is running", test_name);
                    note_error();
                end else begin
                    if (pixel.colour !== colour) begin
                        $display("CHECK FAILED %0s: colour expected %0d actual %0d",
                                 test_name, colour, pixel.colour);
                        note_error();
                    end
                    if (pixel.x >= screen_w || pixel.y >= screen_h) begin
                        $display("error in %0s: pixel (%0d,%0d) lies off the screen",
                                 test_name, pixel.x, pixel.y);
                        note_error();
                    end
                    got_x.push_back(pixel.x);
                    got_y.push_back(pixel.y);
                end
            end
            if (busy && done) begin
                finish_test();
                busy    = 1'b0;
                holding = 1'b1;
            end else if (holding && !done) begin
                if (start_q) begin   // start as the DUT saw it at the edge where done fell
                    $display("error in %0s: done fell while start was still high", test_name);
                    note_error();
                end
                holding = 1'b0;
            end else if (done && !busy && !holding) begin
                $display("error in %0s: done high with no drawing finished", test_name);
                note_error();
            end
        end
        start_q = start;
    end

endmodule

`default_nettype wire

// File: testbench/tb_reuleaux.sv
`timescale 1ns/1ps
`default_nettype none

module tb_reuleaux;

    localparam int screen_w   = 160;
    localparam int screen_h   = 120;
    localparam int n_rows     = 4;
    localparam int wait_limit = 2000;   // cycles per wait

    typedef struct packed {
        logic [8*8-1:0]          name;   // eight characters
        reuleaux_pkg::coord_x_t  cx;
        reuleaux_pkg::coord_y_t  cy;
        logic [7:0]              d;
        reuleaux_pkg::colour_t   colour;
        logic [15:0]             count;  // plotted pixels for the whole triangle
    } test_row_t;

    logic                      clk;
    logic                      rst_n;
    logic                      start;
    reuleaux_pkg::coord_x_t    centre_x;
    reuleaux_pkg::coord_y_t    centre_y;
    logic [7:0]                diameter;
    reuleaux_pkg::colour_t     colour;
    reuleaux_pkg::pixel_t      pixel;
    logic                      done;

    logic [8*8-1:0]            cur_name;
    logic [15:0]               cur_count;
    int                        errors;
    int                        tests;
    int                        row_idx;
    bit                        timed_out;
    test_row_t                 rows [n_rows];

    always #5 clk = ~clk;

    reuleaux_top #(
        .screen_w (screen_w),
        .screen_h (screen_h)
    ) dut_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .centre_x (centre_x),
        .centre_y (centre_y),
        .diameter (diameter),
        .colour   (colour),
        .pixel    (pixel),
        .done     (done)
    );

    reuleaux_checker #(
        .screen_w (screen_w),
        .screen_h (screen_h)
    ) checker_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .centre_x  (centre_x),
        .centre_y  (centre_y),
        .diameter  (diameter),
        .colour    (colour),
        .test_name (cur_name),
        .exp_count (cur_count),
        .pixel     (pixel),
        .done      (done),
        .errors    (errors),
        .tests     (tests)
    );

    // poll done once per cycle until it reaches the level or the limit runs out
    task automatic wait_done_level(input logic level, output bit expired);
        int cycles;
        cycles = 0;
        while (done !== level && cycles < wait_limit) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        expired = (done !== level);
        if (expired) begin
            $display("timeout: done never went %0s in test %0s",
                     level ? "high" : "low", cur_name);
        end
    endtask

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        start     = 1'b0;
        centre_x  = '0;
        centre_y  = '0;
        diameter  = '0;
        colour    = '0;
        cur_name  = "no_test_";
        cur_count = '0;
        timed_out = 1'b0;

        // name, centre x, centre y, diameter, colour, expected plotted pixels
        rows[0] = {"centre40", 8'd80,  7'd60, 8'd40, 3'd5, 16'd118};
        rows[1] = {"corner60", 8'd5,   7'd5,  8'd60, 3'd2, 16'd60};   // clipped left and top
        rows[2] = {"diam_two", 8'd40,  7'd30, 8'd2,  3'd7, 16'd10};
        rows[3] = {"odd_diam", 8'd100, 7'd50, 8'd33, 3'd1, 16'd86};

        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // idle with start low; plot or done here is flagged by the checker
        repeat (5) begin
            @(posedge clk);
            #1;
        end

        for (row_idx = 0; row_idx < n_rows && !timed_out; row_idx++) begin
            centre_x  = rows[row_idx].cx;
            centre_y  = rows[row_idx].cy;
            diameter  = rows[row_idx].d;
            colour    = rows[row_idx].colour;
            cur_name  = rows[row_idx].name;
            cur_count = rows[row_idx].count;
            start     = 1'b1;
            wait_done_level(1'b1, timed_out);
            if (!timed_out) begin
                repeat (4) begin      // keep start high, done must hold
                    @(posedge clk);
                    #1;
                end
                start = 1'b0;
                wait_done_level(1'b0, timed_out);
            end
        end

        @(posedge clk);
        #1;
        $display("tests finished %0d of %0d, errors %0d", tests, n_rows, errors);
        if (timed_out || errors != 0 || tests != n_rows) begin
            $display("TEST FAILED");
        end else begin
            $display("TEST PASSED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
verilog/reuleaux_pkg.sv
verilog/vertex_calc.sv
verilog/arc_engine.sv
verilog/arc_sequencer.sv
verilog/reuleaux_top.sv
testbench/reuleaux_checker.sv
testbench/tb_reuleaux.sv
